/* hdl/csr_pkg.sv */
// shared widths, encodings, masks and struct types for the CSR unit, imported by every block
package csr_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int XLEN     = 32;
    localparam int EDELEG_W = 16;  // delegable exception causes

    // privilege levels with encoding 2 reserved
    typedef enum logic [1:0] {
        PRIV_USER       = 2'd0,
        PRIV_SUPERVISOR = 2'd1,
        PRIV_MACHINE    = 2'd3
    } priv_mode_e;

    // supported CSR addresses
    typedef enum logic [11:0] {
        CSR_SSTATUS   = 12'h100,
        CSR_STVEC     = 12'h105,
        CSR_SSCRATCH  = 12'h140,
        CSR_SEPC      = 12'h141,
        CSR_SCAUSE    = 12'h142,
        CSR_MSTATUS   = 12'h300,
        CSR_MEDELEG   = 12'h302,
        CSR_MTVEC     = 12'h305,
        CSR_MSCRATCH  = 12'h340,
        CSR_MEPC      = 12'h341,
        CSR_MCAUSE    = 12'h342,
        CSR_MVENDORID = 12'hF11,  // read-only id block
        CSR_MARCHID   = 12'hF12,
        CSR_MIMPID    = 12'hF13,
        CSR_MHARTID   = 12'hF14
    } csr_addr_e;

    // ------------------------------------------------------------------------
    // mstatus fields
    // ------------------------------------------------------------------------
    localparam int SIE_BIT  = 1;
    localparam int MIE_BIT  = 3;
    localparam int SPIE_BIT = 5;
    localparam int MPIE_BIT = 7;
    localparam int SPP_BIT  = 8;
    localparam int MPP_LSB  = 11;
    localparam int MPP_W    = 2;

    // implemented bits only
    localparam logic [XLEN-1:0] MSTATUS_MASK = 32'h0000_19AA;
    localparam logic [XLEN-1:0] SSTATUS_MASK = 32'h0000_0122;  // sie, spie, spp

    localparam logic [EDELEG_W-1:0] MEDELEG_MASK = 16'hF7FF;  // ecall from m-mode stays put

    // bit 0 of a tvec selects vectored entry
    localparam logic [XLEN-1:0] TVEC_WR_MASK = 32'hFFFF_FFFD;
    localparam logic [XLEN-1:0] EPC_WR_MASK  = 32'hFFFF_FFFC;

    localparam logic [XLEN-1:0] VENDOR_ID = '0;
    localparam logic [XLEN-1:0] ARCH_ID   = '0;
    localparam logic [XLEN-1:0] IMPL_ID   = '0;

    // ------------------------------------------------------------------------
    // structs
    // ------------------------------------------------------------------------
    typedef struct packed {
        priv_mode_e          mode;
        logic [XLEN-1:0]     mstatus;
        logic [EDELEG_W-1:0] medeleg;
        logic [XLEN-1:0]     mtvec;
        logic [XLEN-1:0]     mscratch;
        logic [XLEN-1:0]     mepc;
        logic [XLEN-1:0]     mcause;
        logic [XLEN-1:0]     stvec;
        logic [XLEN-1:0]     sscratch;
        logic [XLEN-1:0]     sepc;
        logic [XLEN-1:0]     scause;
    } csr_state_t;

    // write-back request
    typedef struct packed {
        logic            valid;
        logic [11:0]     addr;
        logic [XLEN-1:0] data;
    } csr_wr_t;

    // trap entry and trap return request
    typedef struct packed {
        logic            jump;
        logic [XLEN-1:0] cause;   // bit 31 marks an interrupt
        logic [XLEN-1:0] pc;
        logic            rtn;
        priv_mode_e      rtn_mode;
    } trap_req_t;

endpackage

/* hdl/csr_state.sv */
// architectural CSR registers and privilege mode, updated by write-back, trap entry and return
`timescale 1ns/100ps

module csr_state #(
    parameter logic [csr_pkg::XLEN-1:0] RESET_VECTOR = '0
) (
    input  logic                   clk_i,
    input  logic                   resetb_i,
    input  logic                   exs_en_i,
    input  csr_pkg::csr_wr_t       wr_i,
    input  csr_pkg::trap_req_t     trap_i,
    input  csr_pkg::priv_mode_e    target_mode_i,
    output csr_pkg::csr_state_t    state_o
);

    import csr_pkg::*;

    csr_state_t      state_q;
    csr_state_t      state_d;
    logic [XLEN-1:0] wr_mstatus;  // mstatus write value after legalization

    assign state_o = state_q;

    // ------------------------------------------------------------------------
    // next state, one event per cycle
    // ------------------------------------------------------------------------
    always_comb begin
        state_d    = state_q;
        wr_mstatus = wr_i.data & MSTATUS_MASK;
        if (wr_mstatus[MPP_LSB +: MPP_W] == 2'b10) begin
            wr_mstatus[MPP_LSB +: MPP_W] = PRIV_USER;  // reserved mpp reads back as user
        end

        if (trap_i.jump) begin
            if (target_mode_i == PRIV_SUPERVISOR) begin
                state_d.mstatus[SPP_BIT]  = (state_q.mode != PRIV_USER);
                state_d.mstatus[SPIE_BIT] = state_q.mstatus[SIE_BIT];
                state_d.mstatus[SIE_BIT]  = 1'b0;
                state_d.sepc              = trap_i.pc & EPC_WR_MASK;
                state_d.scause            = trap_i.cause;
                state_d.mode              = PRIV_SUPERVISOR;
            end else begin
                state_d.mstatus[MPP_LSB +: MPP_W] = state_q.mode;
                state_d.mstatus[MPIE_BIT]         = state_q.mstatus[MIE_BIT];
                state_d.mstatus[MIE_BIT]          = 1'b0;
                state_d.mepc                      = trap_i.pc & EPC_WR_MASK;
                state_d.mcause                    = trap_i.cause;
                state_d.mode                      = PRIV_MACHINE;
            end
        end else if (trap_i.rtn) begin
            case (trap_i.rtn_mode)
                PRIV_MACHINE: begin  // mret
                    state_d.mode = priv_mode_e'(state_q.mstatus[MPP_LSB +: MPP_W]);
                    state_d.mstatus[MIE_BIT]          = state_q.mstatus[MPIE_BIT];
                    state_d.mstatus[MPIE_BIT]         = 1'b1;
                    state_d.mstatus[MPP_LSB +: MPP_W] = PRIV_USER;
                end
                PRIV_SUPERVISOR: begin  // sret
                    state_d.mode = state_q.mstatus[SPP_BIT] ? PRIV_SUPERVISOR : PRIV_USER;
                    state_d.mstatus[SIE_BIT]  = state_q.mstatus[SPIE_BIT];
                    state_d.mstatus[SPIE_BIT] = 1'b1;
                    state_d.mstatus[SPP_BIT]  = 1'b0;
                end
                default: begin
                end
            endcase
        end else if (wr_i.valid) begin
            case (wr_i.addr)
                CSR_SSTATUS: begin
                    state_d.mstatus = (state_q.mstatus & ~SSTATUS_MASK) |
                                      (wr_i.data & SSTATUS_MASK);
                end
                CSR_STVEC:    state_d.stvec    = wr_i.data & TVEC_WR_MASK;
                CSR_SSCRATCH: state_d.sscratch = wr_i.data;
                CSR_SEPC:     state_d.sepc     = wr_i.data & EPC_WR_MASK;
                CSR_SCAUSE:   state_d.scause   = wr_i.data;
                CSR_MSTATUS:  state_d.mstatus  = wr_mstatus;
                CSR_MEDELEG:  state_d.medeleg  = wr_i.data[EDELEG_W-1:0] & MEDELEG_MASK;
                CSR_MTVEC:    state_d.mtvec    = wr_i.data & TVEC_WR_MASK;
                CSR_MSCRATCH: state_d.mscratch = wr_i.data;
                CSR_MEPC:     state_d.mepc     = wr_i.data & EPC_WR_MASK;
                CSR_MCAUSE:   state_d.mcause   = wr_i.data;
                default: begin  // unknown and read-only addresses
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            state_q.mode     <= PRIV_MACHINE;
            state_q.mstatus  <= '0;  // interrupts off
            state_q.medeleg  <= '0;
            state_q.mtvec    <= RESET_VECTOR & EPC_WR_MASK;  // direct mode
            state_q.mscratch <= '0;
            state_q.mepc     <= '0;
            state_q.mcause   <= '0;
            state_q.stvec    <= '0;
            state_q.sscratch <= '0;
            state_q.sepc     <= '0;
            state_q.scause   <= '0;
        end else if (exs_en_i) begin
            state_q <= state_d;
        end
    end

    // ------------------------------------------------------------------------
    // assertions
    // ------------------------------------------------------------------------
    // mode is loaded from mpp on mret, so this also covers the write legalization
    a_mode_legal: assert property (@(posedge clk_i) disable iff (!resetb_i)
        state_q.mode != 2'b10);

    a_trap_rtn_excl: assert property (@(posedge clk_i) disable iff (!resetb_i)
        exs_en_i |-> !(trap_i.jump && trap_i.rtn));

endmodule

/* hdl/csr_read_port.sv */
// CSR read port with address decode, registered read data and access-violation flags
`timescale 1ns/100ps

module csr_read_port #(
    parameter logic [csr_pkg::XLEN-1:0] HART_ID = '0
) (
    input  logic                      clk_i,
    input  logic                      resetb_i,
    input  logic                      exs_en_i,
    input  logic                      access_i,
    input  logic [11:0]               addr_i,
    input  csr_pkg::csr_state_t       state_i,
    output logic [csr_pkg::XLEN-1:0]  rd_data_o,
    output logic                      bad_csr_addr_o,
    output logic                      readonly_csr_o,
    output logic                      priv_too_low_o
);

    import csr_pkg::*;

    logic [XLEN-1:0] rd_value;
    logic            rd_valid;
    logic [1:0]      addr_type_q;  // addr[11:10]
    logic [1:0]      addr_priv_q;  // addr[9:8], lowest mode allowed

    // ------------------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------------------
    always_comb begin
        rd_value = '0;
        rd_valid = 1'b1;
        case (addr_i)
            CSR_SSTATUS:   rd_value = state_i.mstatus & SSTATUS_MASK;  // restricted view
            CSR_STVEC:     rd_value = state_i.stvec;
            CSR_SSCRATCH:  rd_value = state_i.sscratch;
            CSR_SEPC:      rd_value = state_i.sepc;
            CSR_SCAUSE:    rd_value = state_i.scause;
            CSR_MSTATUS:   rd_value = state_i.mstatus;
            CSR_MEDELEG:   rd_value = {{(XLEN-EDELEG_W){1'b0}}, state_i.medeleg};
            CSR_MTVEC:     rd_value = state_i.mtvec;
            CSR_MSCRATCH:  rd_value = state_i.mscratch;
            CSR_MEPC:      rd_value = state_i.mepc;
            CSR_MCAUSE:    rd_value = state_i.mcause;
            CSR_MVENDORID: rd_value = VENDOR_ID;
            CSR_MARCHID:   rd_value = ARCH_ID;
            CSR_MIMPID:    rd_value = IMPL_ID;
            CSR_MHARTID:   rd_value = HART_ID;
            default: begin
                rd_valid = 1'b0;  // reads as zero
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // output registers, held between accesses
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            rd_data_o      <= '0;
            bad_csr_addr_o <= 1'b0;
            addr_type_q    <= 2'b00;
            addr_priv_q    <= 2'b00;
        end else if (exs_en_i && access_i) begin
            rd_data_o      <= rd_value;
            bad_csr_addr_o <= !rd_valid;
            addr_type_q    <= addr_i[11:10];
            addr_priv_q    <= addr_i[9:8];
        end
    end

    assign readonly_csr_o = (addr_type_q == 2'b11);

    // compared against the live mode, so a mode change after the access shows here
    assign priv_too_low_o = (addr_priv_q > state_i.mode);

    a_rd_known: assert property (@(posedge clk_i) disable iff (!resetb_i)
        (exs_en_i && access_i) |=>
            !$isunknown({rd_data_o, bad_csr_addr_o, readonly_csr_o, priv_too_low_o}));

endmodule

/* hdl/trap_vector_unit.sv */
// trap delegation, entry and return address selection, and interrupt enable for the current mode
`timescale 1ns/100ps

module trap_vector_unit (
    input  csr_pkg::csr_state_t       state_i,
    input  logic [csr_pkg::XLEN-1:0]  excp_cause_i,
    input  csr_pkg::priv_mode_e       trap_rtn_mode_i,
    output csr_pkg::priv_mode_e       target_mode_o,
    output logic [csr_pkg::XLEN-1:0]  trap_entry_addr_o,
    output logic [csr_pkg::XLEN-1:0]  trap_rtn_addr_o,
    output logic                      intr_ext_en_o
);

    import csr_pkg::*;

    logic            delegated;
    logic [XLEN-1:0] tvec;       // tvec of the target mode
    logic [XLEN-1:0] trap_base;

    // ------------------------------------------------------------------------
    // delegation
    // ------------------------------------------------------------------------
    assign delegated = state_i.medeleg[excp_cause_i[3:0]];

    always_comb begin
        case (state_i.mode)
            PRIV_SUPERVISOR,
            PRIV_USER: target_mode_o = delegated ? PRIV_SUPERVISOR : PRIV_MACHINE;
            default:   target_mode_o = PRIV_MACHINE;  // machine traps never go down
        endcase
    end

    // ------------------------------------------------------------------------
    // entry address
    // ------------------------------------------------------------------------
    assign tvec      = (target_mode_o == PRIV_SUPERVISOR) ? state_i.stvec : state_i.mtvec;
    assign trap_base = {tvec[XLEN-1:2], 2'b00};

    always_comb begin
        if (excp_cause_i[XLEN-1] && tvec[0]) begin  // interrupt in vectored mode
            trap_entry_addr_o = trap_base + {excp_cause_i[XLEN-3:0], 2'b00};
        end else begin
            trap_entry_addr_o = trap_base;
        end
    end

    // ------------------------------------------------------------------------
    // return address and interrupt enable
    // ------------------------------------------------------------------------
    always_comb begin
        case (trap_rtn_mode_i)
            PRIV_MACHINE:    trap_rtn_addr_o = state_i.mepc;
            PRIV_SUPERVISOR: trap_rtn_addr_o = state_i.sepc;
            default:         trap_rtn_addr_o = '0;
        endcase
    end

    always_comb begin
        case (state_i.mode)
            PRIV_MACHINE:    intr_ext_en_o = state_i.mstatus[MIE_BIT];
            PRIV_SUPERVISOR: intr_ext_en_o = state_i.mstatus[SIE_BIT];
            default:         intr_ext_en_o = 1'b0;  // no user-level interrupts
        endcase
    end

endmodule

/* hdl/csr_unit.sv */
// CSR unit top level, joins register state, read port and trap vectoring for the execute stage
`timescale 1ns/100ps

module csr_unit #(
    parameter logic [csr_pkg::XLEN-1:0] RESET_VECTOR = '0,
    parameter logic [csr_pkg::XLEN-1:0] HART_ID      = '0
) (
    input  logic                      clk_i,
    input  logic                      resetb_i,
    input  logic                      exs_en_i,
    // read access
    input  logic                      access_i,
    input  logic [11:0]               addr_i,
    output logic [csr_pkg::XLEN-1:0]  rd_data_o,
    output logic                      bad_csr_addr_o,
    output logic                      readonly_csr_o,
    output logic                      priv_too_low_o,
    // write-back
    input  logic                      wr_i,
    input  logic [11:0]               wr_addr_i,
    input  logic [csr_pkg::XLEN-1:0]  wr_data_i,
    // trap entry and return
    input  logic                      jump_to_trap_i,
    input  logic [csr_pkg::XLEN-1:0]  excp_cause_i,
    input  logic [csr_pkg::XLEN-1:0]  excp_pc_i,
    input  logic                      trap_rtn_i,
    input  csr_pkg::priv_mode_e       trap_rtn_mode_i,
    output logic                      intr_ext_en_o,
    output logic [csr_pkg::XLEN-1:0]  trap_entry_addr_o,
    output logic [csr_pkg::XLEN-1:0]  trap_rtn_addr_o,
    output csr_pkg::priv_mode_e       mode_o
);

    import csr_pkg::*;

    csr_wr_t    wr_req;
    trap_req_t  trap_req;
    csr_state_t state;
    priv_mode_e target_mode;

    assign wr_req   = '{valid: wr_i, addr: wr_addr_i, data: wr_data_i};
    assign trap_req = '{jump: jump_to_trap_i, cause: excp_cause_i, pc: excp_pc_i,
                        rtn: trap_rtn_i, rtn_mode: trap_rtn_mode_i};

    assign mode_o = state.mode;

    csr_state #(
        .RESET_VECTOR (RESET_VECTOR)
    ) i_state (
        .clk_i         (clk_i),
        .resetb_i      (resetb_i),
        .exs_en_i      (exs_en_i),
        .wr_i          (wr_req),
        .trap_i        (trap_req),
        .target_mode_i (target_mode),
        .state_o       (state)
    );

    csr_read_port #(
        .HART_ID (HART_ID)
    ) i_read_port (
        .clk_i          (clk_i),
        .resetb_i       (resetb_i),
        .exs_en_i       (exs_en_i),
        .access_i       (access_i),
        .addr_i         (addr_i),
        .state_i        (state),
        .rd_data_o      (rd_data_o),
        .bad_csr_addr_o (bad_csr_addr_o),
        .readonly_csr_o (readonly_csr_o),
        .priv_too_low_o (priv_too_low_o)
    );

    trap_vector_unit i_trap_vector (
        .state_i           (state),
        .excp_cause_i      (excp_cause_i),
        .trap_rtn_mode_i   (trap_rtn_mode_i),
        .target_mode_o     (target_mode),
        .trap_entry_addr_o (trap_entry_addr_o),
        .trap_rtn_addr_o   (trap_rtn_addr_o),
        .intr_ext_en_o     (intr_ext_en_o)
    );

endmodule

/* verif/csr_model.svh */
// reference model of the CSR state and read port, included inside the CSR unit testbench module
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

logic [1:0]  m_mode;
logic [31:0] m_mstatus;
logic [15:0] m_medeleg;
logic [31:0] m_mtvec, m_mscratch, m_mepc, m_mcause;
logic [31:0] m_stvec, m_sscratch, m_sepc, m_scause;
logic [31:0] m_rd_data;    // read port registers
logic        m_bad;
logic [3:0]  m_rd_fields;  // addr[11:8] of the last access

task automatic reset_model();
    m_mode      = 2'd3;
    m_mstatus   = '0;
    m_medeleg   = '0;
    m_mtvec     = TB_RESET_VEC & ~32'h3;
    m_mscratch  = '0;
    m_mepc      = '0;
    m_mcause    = '0;
    m_stvec     = '0;
    m_sscratch  = '0;
    m_sepc      = '0;
    m_scause    = '0;
    m_rd_data   = '0;
    m_bad       = 1'b0;
    m_rd_fields = 4'd0;
endtask

function automatic logic [31:0] read_csr(input logic [11:0] a, output logic valid);
    valid = 1'b1;
    case (a)
        12'h100: return m_mstatus & 32'h122;  // sie, spie, spp only
        12'h105: return m_stvec;
        12'h140: return m_sscratch;
        12'h141: return m_sepc;
        12'h142: return m_scause;
        12'h300: return m_mstatus;
        12'h302: return {16'd0, m_medeleg};
        12'h305: return m_mtvec;
        12'h340: return m_mscratch;
        12'h341: return m_mepc;
        12'h342: return m_mcause;
        12'hF11, 12'hF12, 12'hF13: return '0;
        12'hF14: return TB_HART_ID;
        default: valid = 1'b0;
    endcase
    return '0;
endfunction

task automatic write_csr(input logic [11:0] a, input logic [31:0] d);
    case (a)
        12'h100: m_mstatus = (m_mstatus & ~32'h122) | (d & 32'h122);
        12'h105: m_stvec = d & ~32'h2;
        12'h140: m_sscratch = d;
        12'h141: m_sepc = d & ~32'h3;
        12'h142: m_scause = d;
        12'h300: begin
            m_mstatus = d & 32'h19AA;
            if (m_mstatus[12:11] == 2'b10) begin
                m_mstatus[12:11] = 2'b00;  // reserved mpp becomes user
            end
        end
        12'h302: m_medeleg = d[15:0] & 16'hF7FF;
        12'h305: m_mtvec = d & ~32'h2;
        12'h340: m_mscratch = d;
        12'h341: m_mepc = d & ~32'h3;
        12'h342: m_mcause = d;
        default: ;  // read-only or unknown
    endcase
endtask

function automatic logic [1:0] trap_target(input logic [31:0] cause);
    if (m_mode != 2'd3 && m_medeleg[cause[3:0]]) begin
        return 2'd1;
    end
    return 2'd3;
endfunction

function automatic logic [31:0] entry_addr(input logic [31:0] cause);
    logic [31:0] tvec;
    tvec = (trap_target(cause) == 2'd1) ? m_stvec : m_mtvec;
    if (cause[31] && tvec[0]) begin
        return (tvec & ~32'h3) + {cause[29:0], 2'b00};  // vectored interrupt
    end
    return tvec & ~32'h3;
endfunction

function automatic logic [31:0] return_addr(input logic [1:0] rtn_mode);
    if (rtn_mode == 2'd3) return m_mepc;
    if (rtn_mode == 2'd1) return m_sepc;
    return '0;
endfunction

function automatic logic intr_enable();
    if (m_mode == 2'd3) return m_mstatus[3];
    if (m_mode == 2'd1) return m_mstatus[1];
    return 1'b0;
endfunction

// model update for one rising edge from the inputs the testbench holds
task automatic apply_edge();
    logic        valid;
    logic [31:0] rd;
    logic [1:0]  target;
    if (!exs_en_i) return;  // stage stalled
    rd     = read_csr(addr_i, valid);
    target = trap_target(excp_cause_i);
    if (access_i) begin
        m_rd_data   = rd;
        m_bad       = !valid;
        m_rd_fields = addr_i[11:8];
    end
    if (jump_to_trap_i && target == 2'd1) begin
        m_mstatus[8] = (m_mode != 2'd0);
        m_mstatus[5] = m_mstatus[1];
        m_mstatus[1] = 1'b0;
        m_sepc       = excp_pc_i & ~32'h3;
        m_scause     = excp_cause_i;
        m_mode       = 2'd1;
    end else if (jump_to_trap_i) begin
        m_mstatus[12:11] = m_mode;
        m_mstatus[7]     = m_mstatus[3];
        m_mstatus[3]     = 1'b0;
        m_mepc           = excp_pc_i & ~32'h3;
        m_mcause         = excp_cause_i;
        m_mode           = 2'd3;
    end else if (trap_rtn_i && trap_rtn_mode_i == 2'd3) begin
        m_mode           = m_mstatus[12:11];  // mret
        m_mstatus[3]     = m_mstatus[7];
        m_mstatus[7]     = 1'b1;
        m_mstatus[12:11] = 2'b00;
    end else if (trap_rtn_i && trap_rtn_mode_i == 2'd1) begin
        m_mode       = m_mstatus[8] ? 2'd1 : 2'd0;  // sret
        m_mstatus[1] = m_mstatus[5];
        m_mstatus[5] = 1'b1;
        m_mstatus[8] = 1'b0;
    end else if (wr_i && !trap_rtn_i) begin
        write_csr(wr_addr_i, wr_data_i);  // a return of another mode still blocks it
    end
endtask

`endif

/* verif/tb_csr_unit.sv */
// testbench for the CSR unit, LFSR driven operations checked cycle by cycle against a model
`timescale 1ns/100ps

module tb_csr_unit;

    import csr_pkg::*;

    localparam int          PERIOD       = 100;
    localparam int          N_OPS        = 2000;
    localparam int          N_CYCLES     = N_OPS + 60;  // reset, directed reads and margin
    localparam logic [31:0] TB_RESET_VEC = 32'h8000_0103;
    localparam logic [31:0] TB_HART_ID   = 32'h0000_0007;

    logic        clk_i, resetb_i, exs_en_i, access_i, wr_i, jump_to_trap_i, trap_rtn_i;
    logic [11:0] addr_i, wr_addr_i;
    logic [31:0] wr_data_i, excp_cause_i, excp_pc_i;
    priv_mode_e  trap_rtn_mode_i;
    logic [31:0] rd_data_o, trap_entry_addr_o, trap_rtn_addr_o;
    logic        bad_csr_addr_o, readonly_csr_o, priv_too_low_o, intr_ext_en_o;
    priv_mode_e  mode_o;
    logic [15:0] lfsr_q;
    logic [11:0] csr_table [15] = '{12'h100, 12'h105, 12'h140, 12'h141, 12'h142,
                                   12'h300, 12'h302, 12'h305, 12'h340, 12'h341,
                                   12'h342, 12'hF11, 12'hF12, 12'hF13, 12'hF14};

    `include "csr_model.svh"

    csr_unit #(
        .RESET_VECTOR (TB_RESET_VEC),
        .HART_ID      (TB_HART_ID)
    ) i_dut (.*);

    always #(PERIOD/2) clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        int          k;
        r = '0;
        for (k = 0; k < n; k++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];  // x^16+x^14+x^13+x^11+1
            lfsr_q = {lfsr_q[14:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [11:0] pick_addr();
        logic [3:0] idx;
        idx = 4'(rand_bits(4));
        if (idx == 4'd15) return 12'(rand_bits(12));  // mostly unsupported
        return csr_table[idx];
    endfunction

    task automatic drive_idle();
        {exs_en_i, access_i, wr_i, jump_to_trap_i, trap_rtn_i} = 5'b10000;
        {addr_i, wr_addr_i} = '0;
        {wr_data_i, excp_cause_i, excp_pc_i} = '0;
        trap_rtn_mode_i = PRIV_USER;
    endtask

    task automatic drive_random();
        logic [2:0] op;
        logic [4:0] c;
        op              = 3'(rand_bits(3));
        c               = 5'(rand_bits(5));
        exs_en_i        = |rand_bits(2);  // stalled one cycle in four
        access_i        = (op < 3'd2) | 1'(rand_bits(1));
        addr_i          = pick_addr();
        wr_i            = (op == 3'd2) | (op == 3'd3) | ((op >= 3'd4) & 1'(rand_bits(1)));
        wr_addr_i       = pick_addr();
        wr_data_i       = rand_bits(32);
        jump_to_trap_i  = (op == 3'd4);
        excp_cause_i    = {c[4], 27'd0, c[3:0]};
        excp_pc_i       = rand_bits(32);
        trap_rtn_i      = (op >= 3'd5);
        trap_rtn_mode_i = priv_mode_e'(2'(rand_bits(2)));
        if (op == 3'd5) trap_rtn_mode_i = PRIV_MACHINE;
        if (op == 3'd6) trap_rtn_mode_i = PRIV_SUPERVISOR;
        if (op == 3'd7) trap_rtn_mode_i = priv_mode_e'({1'(rand_bits(1)), 1'b0});  // ignored
    endtask

    // ------------------------------------------------------------------------
    // checking
    // ------------------------------------------------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Error: %s is 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_outputs();
        check_value("rd_data_o", rd_data_o, m_rd_data);
        check_value("bad_csr_addr_o", 32'(bad_csr_addr_o), 32'(m_bad));
        check_value("readonly_csr_o", 32'(readonly_csr_o), 32'(m_rd_fields[3:2] == 2'b11));
        check_value("priv_too_low_o", 32'(priv_too_low_o), 32'(m_rd_fields[1:0] > m_mode));
        check_value("mode_o", 32'(mode_o), 32'(m_mode));
        check_value("intr_ext_en_o", 32'(intr_ext_en_o), 32'(intr_enable()));
        check_value("trap_entry_addr_o", trap_entry_addr_o, entry_addr(excp_cause_i));
        check_value("trap_rtn_addr_o", trap_rtn_addr_o, return_addr(trap_rtn_mode_i));
    endtask

    // inputs settle, outputs checked, model follows the rising edge
    task automatic step_cycle();
        #(PERIOD/4);
        check_outputs();
        @(posedge clk_i);
        apply_edge();
        @(negedge clk_i);
    endtask

    initial begin
        #(N_CYCLES * PERIOD);
        report_failure($sformatf("Timeout: the test did not finish within %0d cycles", N_CYCLES));
    end

    initial begin
        clk_i    = 1'b0;
        resetb_i = 1'b0;
        lfsr_q   = 16'd80;
        drive_idle();
        reset_model();
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        resetb_i = 1'b1;
        // reset values of every supported CSR
        for (int i = 0; i < 15; i++) begin
            drive_idle();
            access_i = 1'b1;
            addr_i   = csr_table[i];
            step_cycle();
        end
        for (int i = 0; i < N_OPS; i++) begin
            drive_random();
            step_cycle();
        end
        drive_idle();
        step_cycle();  // last access checked here
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* csr_unit.f */
+incdir+verif
hdl/csr_pkg.sv
hdl/csr_state.sv
hdl/csr_read_port.sv
hdl/trap_vector_unit.sv
hdl/csr_unit.sv
verif/tb_csr_unit.sv

/* Makefile */
# Verilator build, run and lint for the CSR unit testbench

VERILATOR ?= verilator
TOP       ?= tb_csr_unit
FILELIST  ?= csr_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# fails unless the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
